//--- verilog/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// ROM geometry
`define FETCH_ROM_ADR_BITS  10          // Byte address bits, 256 words

// Fetch queue
`define FETCH_QUEUE_DEPTH   4           // Entries, also the PC stage credit limit

// APB register map
`define FETCH_REG_CTRL      8'h00       // Bit 0 run
`define FETCH_REG_BOOT      8'h04       // Boot pc
`define FETCH_REG_INIT_ADR  8'h08       // Init pointer, data bits 9:2
`define FETCH_REG_INIT_DAT  8'h0C       // Init data, pointer auto increment
`define FETCH_REG_COUNT     8'h10       // Accepted instructions, read only

`endif

//--- verilog/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    typedef logic [31:0]                    pc_t;       // Byte program counter
    typedef logic [31:0]                    word_t;     // Instruction word
    typedef logic [`FETCH_ROM_ADR_BITS-3:0] rom_adr_t;  // ROM word index

    typedef struct packed {
        logic     en;                                   // Read enable, one cycle per read
        rom_adr_t adr;                                  // Word address
        pc_t      pc;                                   // Pc of this read
        logic     epoch;                                // Fetch path tag
    } rom_req_t;

    typedef struct packed {
        logic     vld;                                  // Two cycles after en
        word_t    dat;                                  // Instruction word
        pc_t      pc;                                   // Pc from the request
        logic     epoch;                                // Epoch from the request
    } rom_ret_t;

    typedef struct packed {
        logic     wr;                                   // Init write strobe
        rom_adr_t adr;                                  // Word address
        word_t    dat;                                  // Word to store
    } rom_init_t;

    typedef struct packed {
        word_t    dat;                                  // Instruction word
        pc_t      pc;                                   // Its pc
    } instr_t;

    typedef enum logic {IDLE, ACCESS} apb_state_t;      // APB slave phases

endpackage

//--- verilog/fetch_apb_regs.sv
`timescale 1ns/100ps
`include "fetch_defines.svh"

module fetch_apb_regs
(
    input  logic                    CLK_IN,         // Clock and pclk
    input  logic                    rst_i,          // Active high async reset
    input  logic                    apb_psel_i,     // Slave select
    input  logic                    apb_penable_i,  // Access phase
    input  logic                    apb_pwrite_i,   // Write transfer
    input  logic [7:0]              apb_paddr_i,    // Register offset
    input  fetch_pkg::word_t        apb_pwdata_i,   // Write data
    input  logic                    instr_fire_i,   // Decoder handshake done
    output fetch_pkg::word_t        apb_prdata_o,   // Read data
    output logic                    apb_pready_o,   // Ready in access phase
    output logic                    apb_pslverr_o,  // Error response
    output logic                    run_o,          // Fetch enable
    output fetch_pkg::pc_t          boot_pc_o,      // Start address
    output fetch_pkg::rom_init_t    rom_init_o      // ROM load port
);

    fetch_pkg::apb_state_t  state;                  // Setup / access tracker
    fetch_pkg::rom_adr_t    init_ptr;               // Next ROM word to load
    fetch_pkg::word_t       instr_cnt;              // Accepted instructions
    logic                   acc;                    // Valid access phase
    logic                   err;                    // Refused transfer
    logic                   wr_ok;                  // Write that takes effect
    logic                   sel_ctrl;
    logic                   sel_boot;
    logic                   sel_iadr;
    logic                   sel_idat;
    logic                   sel_cnt;

    // Offset decode
    assign sel_ctrl = (apb_paddr_i == `FETCH_REG_CTRL);
    assign sel_boot = (apb_paddr_i == `FETCH_REG_BOOT);
    assign sel_iadr = (apb_paddr_i == `FETCH_REG_INIT_ADR);
    assign sel_idat = (apb_paddr_i == `FETCH_REG_INIT_DAT);
    assign sel_cnt  = (apb_paddr_i == `FETCH_REG_COUNT);

    assign acc   = (state == fetch_pkg::ACCESS) && apb_psel_i && apb_penable_i;
    assign err   = acc && (!(sel_ctrl || sel_boot || sel_iadr || sel_idat || sel_cnt) ||
                           (apb_pwrite_i && sel_cnt) ||             // COUNT is read only
                           (apb_pwrite_i && sel_idat && run_o));    // No load while running
    assign wr_ok = acc && apb_pwrite_i && !err;

    assign apb_pready_o  = (state == fetch_pkg::ACCESS);  // Zero wait states
    assign apb_pslverr_o = err;

    // Read mux
    always_comb
    begin
        apb_prdata_o = '0;
        if (sel_ctrl)
            apb_prdata_o = {31'd0, run_o};
        else if (sel_boot)
            apb_prdata_o = boot_pc_o;
        else if (sel_iadr)
            apb_prdata_o = {{(32 - `FETCH_ROM_ADR_BITS){1'b0}}, init_ptr, 2'b00};
        else if (sel_cnt)
            apb_prdata_o = instr_cnt;
    end

    // One ROM word per INIT_DAT write in the access cycle
    assign rom_init_o.wr  = wr_ok && sel_idat;
    assign rom_init_o.adr = init_ptr;
    assign rom_init_o.dat = apb_pwdata_i;

    always_ff @(posedge CLK_IN or posedge rst_i)
    begin
        if (rst_i)
        begin
            state     <= fetch_pkg::IDLE;
            run_o     <= 1'b0;
            boot_pc_o <= '0;
            init_ptr  <= '0;
            instr_cnt <= '0;
        end
        else
        begin
            case (state)
                fetch_pkg::IDLE :
                    if (apb_psel_i && !apb_penable_i)
                        state <= fetch_pkg::ACCESS;
                default :
                    state <= fetch_pkg::IDLE;                   // Access lasts one cycle
            endcase
            if (wr_ok && sel_ctrl)
                run_o <= apb_pwdata_i[0];
            if (wr_ok && sel_boot)
                boot_pc_o <= {apb_pwdata_i[31:2], 2'b00};       // Word aligned
            if (wr_ok && sel_iadr)
                init_ptr <= apb_pwdata_i[`FETCH_ROM_ADR_BITS-1:2];
            else if (wr_ok && sel_idat)
                init_ptr <= init_ptr + 1'b1;                    // Wraps at 256
            if (instr_fire_i)
                instr_cnt <= instr_cnt + 1'b1;
        end
    end

    // Ready only answers a selected access phase of the host
    a_pready_access: assert property (@(posedge CLK_IN) disable iff (rst_i)
        apb_pready_o |-> apb_psel_i && apb_penable_i);

endmodule

//--- verilog/fetch_pc_stage.sv
`timescale 1ns/100ps
`include "fetch_defines.svh"

module fetch_pc_stage
(
    input  logic                    CLK_IN,         // Clock
    input  logic                    rst_i,          // Async reset, active high
    input  logic                    run_i,          // Fetch enable
    input  fetch_pkg::pc_t          boot_pc_i,      // Start address
    input  logic                    redirect_i,     // Decoder redirect
    input  fetch_pkg::pc_t          redirect_pc_i,  // Redirect target
    input  logic                    credit_i,       // One slot freed by a pop
    input  logic [2:0]              credit_cnt_i,   // Slots freed by flush or drop
    output fetch_pkg::rom_req_t     rom_req_o,      // ROM read request
    output logic                    run_start_o     // Run rising edge pulse
);

    logic                   run_q;                  // Run, one cycle late
    fetch_pkg::pc_t         pc_q;                   // Next pc to fetch
    logic                   epoch_q;                // Current path tag
    logic [2:0]             outst;                  // Slots in flight or queued
    logic [2:0]             committed;              // Outstanding less this cycle's returns
    logic                   issue;                  // Read issued this cycle
    fetch_pkg::pc_t         issue_pc;
    logic                   issue_epoch;

    assign run_start_o = run_i && !run_q;

    // Start issues straight from BOOT with the new epoch
    assign issue_pc    = run_start_o ? boot_pc_i : pc_q;
    assign issue_epoch = run_start_o ? ~epoch_q : epoch_q;

    // Flush credit counts at once so a restart never overshoots
    assign committed = outst - credit_cnt_i;
    assign issue     = run_i && !redirect_i && (committed < `FETCH_QUEUE_DEPTH);

    assign rom_req_o.en    = issue;
    assign rom_req_o.adr   = issue_pc[`FETCH_ROM_ADR_BITS-1:2];
    assign rom_req_o.pc    = issue_pc;
    assign rom_req_o.epoch = issue_epoch;

    always_ff @(posedge CLK_IN or posedge rst_i)
    begin
        if (rst_i)
        begin
            run_q   <= 1'b0;
            pc_q    <= '0;
            epoch_q <= 1'b0;
            outst   <= '0;
        end
        else
        begin
            run_q <= run_i;
            if (redirect_i)
                pc_q <= redirect_pc_i;                          // Issued next cycle
            else if (issue)
                pc_q <= issue_pc + 32'd4;
            else if (run_start_o)
                pc_q <= boot_pc_i;                              // Start without credit
            if (redirect_i || run_start_o)
                epoch_q <= ~epoch_q;                            // Old path now stale
            outst <= outst + {2'b00, issue} - {2'b00, credit_i} - credit_cnt_i;
        end
    end

    // Credit loop with the queue keeps the slot count in range
    a_credit_limit: assert property (@(posedge CLK_IN) disable iff (rst_i)
        outst <= `FETCH_QUEUE_DEPTH);

endmodule

//--- verilog/instr_rom.sv
`timescale 1ns/100ps
`include "fetch_defines.svh"

module instr_rom
(
    input  logic                    CLK_IN,         // Clock
    input  logic                    rst_i,          // Async reset, active high
    input  fetch_pkg::rom_req_t     rom_req_i,      // Read request
    input  fetch_pkg::rom_init_t    rom_init_i,     // Load write
    output fetch_pkg::rom_ret_t     rom_ret_o       // Read return
);

    localparam int WORDS = 2 ** (`FETCH_ROM_ADR_BITS - 2);

    fetch_pkg::word_t       mem [WORDS];            // Instruction image
    fetch_pkg::word_t       s1_dat;                 // Array read register
    fetch_pkg::word_t       s2_dat;                 // Output register
    fetch_pkg::pc_t         s1_pc;
    fetch_pkg::pc_t         s2_pc;
    logic                   s1_epoch;
    logic                   s2_epoch;
    logic [1:0]             vld;                    // Valid pipe

    // Single port, write wins
    always_ff @(posedge CLK_IN)
    begin
        if (rom_init_i.wr)
            mem[rom_init_i.adr] <= rom_init_i.dat;
        else if (rom_req_i.en)
            s1_dat <= mem[rom_req_i.adr];
    end

    // Tag pipe beside the data
    always_ff @(posedge CLK_IN)
    begin
        if (rom_req_i.en)
        begin
            s1_pc    <= rom_req_i.pc;
            s1_epoch <= rom_req_i.epoch;
        end
        if (vld[0])
        begin
            s2_dat   <= s1_dat;                         // Second stage follows valid
            s2_pc    <= s1_pc;
            s2_epoch <= s1_epoch;
        end
    end

    always_ff @(posedge CLK_IN or posedge rst_i)
    begin
        if (rst_i)
            vld <= 2'b00;
        else
            vld <= {vld[0], rom_req_i.en && !rom_init_i.wr};
    end

    assign rom_ret_o.vld   = vld[1];                    // Two cycles after en
    assign rom_ret_o.dat   = s2_dat;
    assign rom_ret_o.pc    = s2_pc;
    assign rom_ret_o.epoch = s2_epoch;

    // Loading and fetching are kept apart by the run bit
    a_no_init_read: assert property (@(posedge CLK_IN) disable iff (rst_i)
        !(rom_init_i.wr && rom_req_i.en));

endmodule

//--- verilog/fetch_queue.sv
`timescale 1ns/100ps
`include "fetch_defines.svh"

module fetch_queue
(
    input  logic                    CLK_IN,         // Clock
    input  logic                    rst_i,          // Async reset, active high
    input  fetch_pkg::rom_ret_t     rom_ret_i,      // ROM return
    input  logic                    redirect_i,     // Decoder redirect
    input  logic                    run_start_i,    // Run rising edge pulse
    input  logic                    instr_ready_i,  // Decoder ready
    output logic                    credit_o,       // One slot freed by a pop
    output logic [2:0]              credit_cnt_o,   // Slots freed by flush or drop
    output fetch_pkg::instr_t       instr_o,        // Head entry
    output logic                    instr_valid_o   // Head entry valid
);

    localparam int PTR_BITS = $clog2(`FETCH_QUEUE_DEPTH);

    fetch_pkg::instr_t      mem [`FETCH_QUEUE_DEPTH];  // Entry storage
    logic [PTR_BITS-1:0]    wr_ptr;
    logic [PTR_BITS-1:0]    rd_ptr;
    logic [2:0]             fill;                   // Entries held
    logic                   epoch_q;                // Local copy of the path tag
    logic                   flush;
    logic                   drop;                   // Stale return discarded
    logic                   push;
    logic                   pop;

    assign flush = redirect_i || run_start_i;
    assign drop  = rom_ret_i.vld && (flush || (rom_ret_i.epoch != epoch_q));
    assign push  = rom_ret_i.vld && !drop;
    assign pop   = instr_valid_o && instr_ready_i;

    // Flushed entries include a same-cycle pop
    assign credit_o     = pop && !flush;
    assign credit_cnt_o = (flush ? fill : 3'd0) + {2'b00, drop};

    assign instr_valid_o = (fill != 3'd0);
    assign instr_o       = mem[rd_ptr];             // Visible the cycle after arrival

    always_ff @(posedge CLK_IN)
    begin
        if (push)
        begin
            mem[wr_ptr].dat <= rom_ret_i.dat;
            mem[wr_ptr].pc  <= rom_ret_i.pc;
        end
    end

    always_ff @(posedge CLK_IN or posedge rst_i)
    begin
        if (rst_i)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            epoch_q <= 1'b0;
        end
        else if (flush)
        begin
            wr_ptr  <= '0;                              // Empty, nothing pushed
            rd_ptr  <= '0;
            fill    <= '0;
            epoch_q <= ~epoch_q;                        // Tracks the PC stage toggle
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            fill <= fill + {2'b00, push} - {2'b00, pop};
        end
    end

    // Credit in the PC stage bounds the returns in flight
    a_no_overflow: assert property (@(posedge CLK_IN) disable iff (rst_i)
        push |-> (fill < `FETCH_QUEUE_DEPTH));

endmodule

//--- verilog/fetch_top.sv
`timescale 1ns/100ps

module fetch_top
(
    input  logic                    CLK_IN,         // Clock, also pclk
    input  logic                    rst_i,          // Async reset, active high
    input  logic                    apb_psel_i,
    input  logic                    apb_penable_i,
    input  logic                    apb_pwrite_i,
    input  logic [7:0]              apb_paddr_i,
    input  fetch_pkg::word_t        apb_pwdata_i,
    output fetch_pkg::word_t        apb_prdata_o,
    output logic                    apb_pready_o,
    output logic                    apb_pslverr_o,
    input  logic                    redirect_i,     // Decoder redirect
    input  fetch_pkg::pc_t          redirect_pc_i,  // Redirect target
    output fetch_pkg::instr_t       instr_o,        // To decoder
    output logic                    instr_valid_o,
    input  logic                    instr_ready_i
);

    logic                   run;
    logic                   run_start;
    logic                   credit;
    logic [2:0]             credit_cnt;
    logic                   instr_fire;             // Accepted by decoder
    fetch_pkg::pc_t         boot_pc;
    fetch_pkg::rom_init_t   rom_init;
    fetch_pkg::rom_req_t    rom_req;
    fetch_pkg::rom_ret_t    rom_ret;

    assign instr_fire = instr_valid_o && instr_ready_i;

    fetch_apb_regs u_regs (.CLK_IN(CLK_IN), .rst_i(rst_i), .apb_psel_i(apb_psel_i),
        .apb_penable_i(apb_penable_i), .apb_pwrite_i(apb_pwrite_i), .apb_paddr_i(apb_paddr_i),
        .apb_pwdata_i(apb_pwdata_i), .instr_fire_i(instr_fire), .apb_prdata_o(apb_prdata_o),
        .apb_pready_o(apb_pready_o), .apb_pslverr_o(apb_pslverr_o), .run_o(run),
        .boot_pc_o(boot_pc), .rom_init_o(rom_init));

    fetch_pc_stage u_pc (.CLK_IN(CLK_IN), .rst_i(rst_i), .run_i(run), .boot_pc_i(boot_pc),
        .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i), .credit_i(credit),
        .credit_cnt_i(credit_cnt), .rom_req_o(rom_req), .run_start_o(run_start));

    instr_rom u_rom (.CLK_IN(CLK_IN), .rst_i(rst_i), .rom_req_i(rom_req),
        .rom_init_i(rom_init), .rom_ret_o(rom_ret));

    fetch_queue u_queue (.CLK_IN(CLK_IN), .rst_i(rst_i), .rom_ret_i(rom_ret),
        .redirect_i(redirect_i), .run_start_i(run_start), .instr_ready_i(instr_ready_i),
        .credit_o(credit), .credit_cnt_o(credit_cnt), .instr_o(instr_o),
        .instr_valid_o(instr_valid_o));

endmodule

//--- verification/fetch_tb_model.svh
`ifndef FETCH_TB_MODEL_SVH
`define FETCH_TB_MODEL_SVH

logic [31:0]    image [256];                    // Expected ROM image
logic [7:0]     init_ptr_m;                     // Init word pointer
logic           run_m;                          // Run bit
logic [31:0]    boot_m;                         // Boot pc
logic [31:0]    exp_pc;                         // Pc the decoder should see next
int unsigned    hs_count;                       // Handshakes observed

function automatic void model_reset();
    run_m      = 1'b0;
    boot_m     = '0;
    init_ptr_m = '0;
    exp_pc     = '0;
    hs_count   = 0;
endfunction

// Word at pc / 4 mod 256
function automatic logic [31:0] image_word(input logic [31:0] pc);
    return image[(pc >> 2) % 256];
endfunction

function automatic void accept_instr();
    exp_pc   = exp_pc + 32'd4;                  // Sequential path, wraps at 2^32
    hs_count = hs_count + 1;
endfunction

function automatic logic model_reg_error(input logic wr, input logic [7:0] adr);
    logic mapped;
    mapped = (adr == `FETCH_REG_CTRL) || (adr == `FETCH_REG_BOOT) ||
             (adr == `FETCH_REG_INIT_ADR) || (adr == `FETCH_REG_INIT_DAT) ||
             (adr == `FETCH_REG_COUNT);
    return !mapped || (wr && adr == `FETCH_REG_COUNT) ||
           (wr && adr == `FETCH_REG_INIT_DAT && run_m);
endfunction

function automatic logic [31:0] model_reg_read(input logic [7:0] adr);
    case (adr)
        `FETCH_REG_CTRL     : return {31'd0, run_m};
        `FETCH_REG_BOOT     : return boot_m;
        `FETCH_REG_INIT_ADR : return {22'd0, init_ptr_m, 2'b00};
        `FETCH_REG_COUNT    : return hs_count;
        default             : return 32'd0;
    endcase
endfunction

function automatic void model_reg_write(input logic [7:0] adr, input logic [31:0] dat);
    case (adr)
        `FETCH_REG_CTRL :
        begin
            if (dat[0] && !run_m)
                exp_pc = boot_m;                // Run start fetches from BOOT
            run_m = dat[0];
        end
        `FETCH_REG_BOOT     : boot_m = {dat[31:2], 2'b00};
        `FETCH_REG_INIT_ADR : init_ptr_m = dat[9:2];
        `FETCH_REG_INIT_DAT :
        begin
            image[init_ptr_m] = dat;
            init_ptr_m        = init_ptr_m + 8'd1;  // Wraps at 256
        end
        default : ;
    endcase
endfunction

`endif

//--- verification/tb_fetch_top.sv
`timescale 1ns/100ps
`include "fetch_defines.svh"

module tb_fetch_top;

    logic                   CLK_IN;
    logic                   rst_i;
    logic                   apb_psel;
    logic                   apb_penable;
    logic                   apb_pwrite;
    logic [7:0]             apb_paddr;
    fetch_pkg::word_t       apb_pwdata;
    fetch_pkg::word_t       apb_prdata;
    logic                   apb_pready;
    logic                   apb_pslverr;
    logic                   redirect;
    fetch_pkg::pc_t         redirect_pc;
    fetch_pkg::instr_t      instr;
    logic                   instr_valid;
    logic                   instr_ready;

    integer                 seed;                   // $random state
    int                     err_count;
    int                     timeout_count;
    int                     check_count;
    int                     stall;                  // Ready cycles without a word while running
    string                  test_name;

    `include "fetch_tb_model.svh"

    fetch_top dut0 (.CLK_IN(CLK_IN), .rst_i(rst_i), .apb_psel_i(apb_psel),
        .apb_penable_i(apb_penable), .apb_pwrite_i(apb_pwrite), .apb_paddr_i(apb_paddr),
        .apb_pwdata_i(apb_pwdata), .apb_prdata_o(apb_prdata), .apb_pready_o(apb_pready),
        .apb_pslverr_o(apb_pslverr), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .instr_o(instr), .instr_valid_o(instr_valid), .instr_ready_i(instr_ready));

    initial
    begin
        CLK_IN = 1'b0;
        forever #20 CLK_IN = ~CLK_IN;               // 40 ns period
    end

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        if (exp !== act)
        begin
            err_count++;
            $display("MISMATCH %s %s: expected 0x%08h, actual 0x%08h",
                     test_name, what, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("Timeout in %s: %s did not happen in time", test_name, what);
    endtask

    // Setup cycle then access cycle until pready
    task automatic apb_transfer(input logic wr, input logic [7:0] adr, input logic [31:0] wdat,
                                output logic [31:0] rdat, output logic slverr);
        int n;
        @(posedge CLK_IN);
        #2;
        apb_psel    = 1'b1;
        apb_penable = 1'b0;
        apb_pwrite  = wr;
        apb_paddr   = adr;
        apb_pwdata  = wdat;
        @(posedge CLK_IN);
        #2;
        apb_penable = 1'b1;
        n = 0;
        @(negedge CLK_IN);                          // Sample mid cycle
        while (!apb_pready && n < 8)
        begin
            @(negedge CLK_IN);
            n++;
        end
        if (!apb_pready)
            report_timeout("APB pready");
        rdat   = apb_prdata;
        slverr = apb_pslverr;
        @(posedge CLK_IN);
        #2;
        apb_psel    = 1'b0;
        apb_penable = 1'b0;
    endtask

    // Register access checked against the model which follows accepted writes
    task automatic reg_access(input logic wr, input logic [7:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        logic           exp_err;
        logic [31:0]    exp_dat;
        logic           slverr;
        exp_err = model_reg_error(wr, adr);
        exp_dat = model_reg_read(adr);
        apb_transfer(wr, adr, wdat, rdat, slverr);
        check_value("pslverr", {31'd0, exp_err}, {31'd0, slverr});
        if (!wr && !exp_err)
            check_value("read data", exp_dat, rdat);
        if (wr && !exp_err)
            model_reg_write(adr, wdat);
    endtask

    task automatic set_ready(input logic val);
        @(posedge CLK_IN);
        #2;
        instr_ready = val;
    endtask

    // Random ready and optional redirects per cycle
    task automatic run_traffic(input int cycles, input int ready_pct, input bit with_redirect);
        int gap;
        gap = 8;
        repeat (cycles)
        begin
            @(posedge CLK_IN);
            #2;
            instr_ready = ({$random(seed)} % 100) < ready_pct;
            redirect    = 1'b0;
            if (with_redirect)
            begin
                gap = gap - 1;
                if (gap == 0)
                begin
                    redirect    = 1'b1;
                    redirect_pc = $random(seed) & 32'hffff_fffc;  // Word aligned target
                    gap         = 5 + {$random(seed)} % 30;
                end
            end
        end
        @(posedge CLK_IN);
        #2;
        redirect = 1'b0;
    endtask

    // Hold ready until the queue and the ROM pipe stay empty
    task automatic drain_queue();
        int quiet;
        int n;
        quiet = 0;
        n     = 0;
        set_ready(1'b1);
        while (quiet < 4 && n < 64)
        begin
            @(negedge CLK_IN);
            quiet = instr_valid ? 0 : quiet + 1;
            n++;
        end
        if (quiet < 4)
            report_timeout("queue drain");
    endtask

    // Every handshake must match the model stream
    always @(negedge CLK_IN)
    begin
        if (!rst_i && instr_valid && instr_ready)
        begin
            check_value("pc", exp_pc, instr.pc);
            check_value("word", image_word(exp_pc), instr.dat);
            accept_instr();
        end
        // A running front end with a ready decoder delivers within a few cycles
        if (!rst_i && run_m && instr_ready && !instr_valid)
            stall++;
        else
            stall = 0;
        if (stall == 16)
            report_timeout("instruction delivery");
        if (!rst_i && redirect)
            exp_pc = redirect_pc;                   // Next word comes from the target
    end

    initial
    begin
        logic [31:0]    rd;
        int             n;
        seed          = 32'hc5e8bb9b;
        err_count     = 0;
        timeout_count = 0;
        check_count   = 0;
        stall         = 0;
        test_name     = "reset";
        rst_i         = 1'b1;
        apb_psel      = 1'b0;
        apb_penable   = 1'b0;
        apb_pwrite    = 1'b0;
        apb_paddr     = '0;
        apb_pwdata    = '0;
        redirect      = 1'b0;
        redirect_pc   = '0;
        instr_ready   = 1'b0;
        model_reset();
        repeat (8) @(posedge CLK_IN);
        #2;
        rst_i = 1'b0;

        @(negedge CLK_IN);
        check_value("instr_valid", 32'd0, {31'd0, instr_valid});
        check_value("idle pslverr", 32'd0, {31'd0, apb_pslverr});
        reg_access(1'b0, `FETCH_REG_COUNT, 32'd0, rd);     // Zero after reset

        test_name = "load";
        reg_access(1'b1, `FETCH_REG_INIT_ADR, 32'd0, rd);
        for (n = 0; n < 256; n++)
            reg_access(1'b1, `FETCH_REG_INIT_DAT, $random(seed), rd);
        reg_access(1'b1, `FETCH_REG_BOOT, 32'hffff_ff00, rd);  // Path wraps through zero

        test_name = "sequential";
        set_ready(1'b1);
        reg_access(1'b1, `FETCH_REG_CTRL, 32'd1, rd);
        n = 0;
        while (!instr_valid && n < 16)
        begin
            @(negedge CLK_IN);
            n++;
        end
        if (!instr_valid)
            report_timeout("first instruction");
        check_value("first fetch latency", 32'd4, n);
        run_traffic(120, 100, 1'b0);

        test_name = "backpressure";
        run_traffic(400, 50, 1'b0);

        test_name = "redirect";
        run_traffic(800, 70, 1'b1);

        test_name = "counter";
        set_ready(1'b0);                            // Freeze the handshake count
        reg_access(1'b0, `FETCH_REG_COUNT, 32'd0, rd);

        test_name = "errors";
        reg_access(1'b1, `FETCH_REG_INIT_DAT, ~image[0], rd);  // Refused while running
        reg_access(1'b0, 8'h14, 32'd0, rd);
        reg_access(1'b1, `FETCH_REG_COUNT, 32'd0, rd);
        reg_access(1'b0, `FETCH_REG_INIT_ADR, 32'd0, rd);      // Pointer untouched

        test_name = "restart";
        reg_access(1'b1, `FETCH_REG_CTRL, 32'd0, rd);
        drain_queue();
        reg_access(1'b1, `FETCH_REG_BOOT, 32'h0000_0000, rd);  // Starts on word 0
        reg_access(1'b1, `FETCH_REG_CTRL, 32'd1, rd);
        run_traffic(300, 60, 1'b0);
        set_ready(1'b0);
        reg_access(1'b0, `FETCH_REG_COUNT, 32'd0, rd);
        reg_access(1'b0, `FETCH_REG_CTRL, 32'd0, rd);

        $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
                 check_count, err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0 && check_count > 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+verilog
+incdir+verification
verilog/fetch_pkg.sv
verilog/fetch_apb_regs.sv
verilog/fetch_pc_stage.sv
verilog/instr_rom.sv
verilog/fetch_queue.sv
verilog/fetch_top.sv
verification/tb_fetch_top.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_fetch_top \
    -Mdir "$OBJ" -o sim_fetch
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/sim_fetch" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

grep -qx "Result: PASSED" "$LOG"
if [ $? -ne 0 ]; then
    echo "Pass message not found in $LOG"
    exit 1
fi

exit 0
